// ==== verilog/vmul_pkg.sv ====
package vmul_pkg;

  // default configuration, the unit top can override all of these
  // log2 of the element width, 4 gives 16 bit elements
  localparam int LOG2_WIDTH_DEF    = 4;
  // operand elements per vector instruction
  localparam int NUM_LANES_DEF     = 8;
  // physical multipliers, the vector is worked through in groups of this size
  localparam int NUM_MUL_LANES_DEF = 2;
  // destination register id width
  localparam int REG_ID_WIDTH_DEF  = 5;

  // one vector element at the default width
  typedef logic [2**LOG2_WIDTH_DEF-1:0] elem_t;

  // destination register id
  typedef logic [REG_ID_WIDTH_DEF-1:0] reg_id_t;

  // operation code seen by the unit
  // codes 6 and 7 are unused and fall back to a low multiply
  typedef enum logic [2:0] {
    // signed multiply, low half of the product
    op_mull  = 3'd0,
    // signed multiply, high half
    op_mulh  = 3'd1,
    // unsigned multiply, high half
    op_mulhu = 3'd2,
    // logical left shift
    op_sll   = 3'd3,
    // logical right shift
    op_srl   = 3'd4,
    // arithmetic right shift
    op_sra   = 3'd5
  } vmul_op_e;

endpackage

// ==== verilog/vmul_group_if.sv ====
interface vmul_group_if #(
  parameter int ELEM_WIDTH    = 2**vmul_pkg::LOG2_WIDTH_DEF,
  parameter int NUM_MUL_LANES = vmul_pkg::NUM_MUL_LANES_DEF
);

  // operands of the group that is in the multipliers this cycle
  logic [NUM_MUL_LANES*ELEM_WIDTH-1:0] op_a;
  logic [NUM_MUL_LANES*ELEM_WIDTH-1:0] op_b;

  // decoded controls, constant over one instruction
  logic is_shift;
  logic shift_right;
  logic shift_arith;
  logic take_high;
  logic is_signed;

  // lane registers load when high
  logic lane_en;

  // registered lane results, one cycle behind the operands
  logic [NUM_MUL_LANES*ELEM_WIDTH-1:0] res;

  modport decode (output is_shift, shift_right, shift_arith, take_high, is_signed);
  modport feed (output op_a, op_b, lane_en);
  modport lane (input op_a, op_b, is_shift, shift_right, shift_arith, take_high,
                is_signed, lane_en, output res);
  modport collect (input res, lane_en);

endinterface

// ==== verilog/vmul_op_decode.sv ====
module vmul_op_decode (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               activate,
  input  logic               issue,
  input  vmul_pkg::vmul_op_e op,
  vmul_group_if.decode       grp
);

  import vmul_pkg::*;

  // control bit order is {is_shift, shift_right, shift_arith, take_high, is_signed}
  logic [4:0] dec;
  logic [4:0] ctrl_q;
  logic [4:0] ctrl;

  // fresh decode of the op input
  // held at zero while nothing is requested so the lanes see no toggling
  always_comb
  begin
    dec = '0;
    if (activate)
    begin
      case (op)
        op_mull:  dec = 5'b00001;
        op_mulh:  dec = 5'b00011;
        op_mulhu: dec = 5'b00010;
        op_sll:   dec = 5'b10000;
        op_srl:   dec = 5'b11000;
        op_sra:   dec = 5'b11100;
        default:  dec = 5'b00001;
      endcase
    end
  end

  // keep the decode of the issued op for groups 1 to G-1
  // the op input is free to move on once stall is up
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      ctrl_q <= '0;
    else if (issue)
      ctrl_q <= dec;
  end

  // group 0 goes out in the issue cycle, so pass the live decode then
  assign ctrl = issue ? dec : ctrl_q;

  assign {grp.is_shift, grp.shift_right, grp.shift_arith, grp.take_high, grp.is_signed} = ctrl;

endmodule

// ==== verilog/vmul_group_sequencer.sv ====
module vmul_group_sequencer #(
  parameter int LOG2_WIDTH    = vmul_pkg::LOG2_WIDTH_DEF,
  parameter int NUM_LANES     = vmul_pkg::NUM_LANES_DEF,
  parameter int NUM_MUL_LANES = vmul_pkg::NUM_MUL_LANES_DEF
) (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 activate,
  input  logic [NUM_LANES*(2**LOG2_WIDTH)-1:0] op_a,
  input  logic [NUM_LANES*(2**LOG2_WIDTH)-1:0] op_b,
  output logic                                 issue,
  output logic                                 stall,
  vmul_group_if.feed                           grp
);

  localparam int ELEM_W   = 2**LOG2_WIDTH;
  localparam int VEC_W    = NUM_LANES*ELEM_W;
  // bits handed to the multipliers per cycle
  localparam int GRP_W    = NUM_MUL_LANES*ELEM_W;
  localparam int NUM_GRPS = NUM_LANES/NUM_MUL_LANES;
  // wide enough for G-1, never zero bits wide
  localparam int CNT_W    = $clog2(NUM_GRPS+1);

  // groups still to go after the current one
  logic [CNT_W-1:0] grp_cnt;
  logic             busy;

  // operand shift buffers, group 1 sits in the low bits after issue
  logic [VEC_W-1:0] op_a_buf;
  logic [VEC_W-1:0] op_b_buf;

  assign busy = (grp_cnt != '0);

  // a request while busy is not taken, upstream holds it under stall
  assign issue = activate & ~busy;
  assign stall = busy;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      grp_cnt <= '0;
    else if (issue)
      grp_cnt <= CNT_W'(NUM_GRPS-1);
    else if (busy)
      grp_cnt <= grp_cnt - 1'b1;
  end

  // group 0 bypasses the buffers, so load what comes after it
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      op_a_buf <= op_a >> GRP_W;
      op_b_buf <= op_b >> GRP_W;
    end
    else if (busy)
    begin
      op_a_buf <= op_a_buf >> GRP_W;
      op_b_buf <= op_b_buf >> GRP_W;
    end
  end

  // live group 0 in the issue cycle, buffered groups while stalled
  assign grp.op_a = busy ? op_a_buf[GRP_W-1:0] : op_a[GRP_W-1:0];
  assign grp.op_b = busy ? op_b_buf[GRP_W-1:0] : op_b[GRP_W-1:0];

  // lanes take a new group in every cycle that carries one
  assign grp.lane_en = issue | busy;

endmodule

// ==== verilog/vmul_mulshift_lane.sv ====
module vmul_mulshift_lane #(
  parameter int LOG2_WIDTH = vmul_pkg::LOG2_WIDTH_DEF,
  parameter int LANE       = 0
) (
  input logic        clk,
  input logic        arst_n,
  vmul_group_if.lane grp
);

  localparam int ELEM_W = 2**LOG2_WIDTH;

  logic [ELEM_W-1:0]          a;
  logic [ELEM_W-1:0]          b;
  logic [LOG2_WIDTH-1:0]      shamt;
  // one extra bit so one signed multiplier serves both signed and unsigned
  logic signed [ELEM_W:0]     a_ext;
  logic signed [ELEM_W:0]     b_ext;
  logic signed [2*ELEM_W+1:0] prod;
  logic signed [ELEM_W:0]     shr_ext;
  logic signed [ELEM_W:0]     shr_full;
  logic [ELEM_W-1:0]          res_d;
  logic [ELEM_W-1:0]          res_q;

  // this lane's slice of the group
  assign a     = grp.op_a[LANE*ELEM_W +: ELEM_W];
  assign b     = grp.op_b[LANE*ELEM_W +: ELEM_W];
  // shift amount is the low bits of op_b, upper bits ignored
  assign shamt = b[LOG2_WIDTH-1:0];

  // sign extend for signed ops, zero extend for mulhu
  assign a_ext = {grp.is_signed & a[ELEM_W-1], a};
  assign b_ext = {grp.is_signed & b[ELEM_W-1], b};
  assign prod  = a_ext * b_ext;

  // sign fill only on sra, srl shifts in zeros
  assign shr_ext  = {grp.shift_arith & a[ELEM_W-1], a};
  assign shr_full = shr_ext >>> shamt;

  always_comb
  begin
    if (grp.is_shift)
    begin
      if (grp.shift_right)
        res_d = shr_full[ELEM_W-1:0];
      else
        res_d = a << shamt;
    end
    else if (grp.take_high)
      res_d = prod[2*ELEM_W-1:ELEM_W];
    else
      res_d = prod[ELEM_W-1:0];
  end

  // fixed latency of one, holds between instructions
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      res_q <= '0;
    else if (grp.lane_en)
      res_q <= res_d;
  end

  assign grp.res[LANE*ELEM_W +: ELEM_W] = res_q;

endmodule

// ==== verilog/vmul_result_collect.sv ====
module vmul_result_collect #(
  parameter int LOG2_WIDTH    = vmul_pkg::LOG2_WIDTH_DEF,
  parameter int NUM_LANES     = vmul_pkg::NUM_LANES_DEF,
  parameter int NUM_MUL_LANES = vmul_pkg::NUM_MUL_LANES_DEF
) (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 issue,
  input  logic                                 squash,
  input  vmul_pkg::reg_id_t                    in_dst,
  input  logic                                 in_dst_we,
  input  logic [NUM_LANES-1:0]                 in_mask,
  vmul_group_if.collect                        grp,
  output logic [NUM_LANES*(2**LOG2_WIDTH)-1:0] result,
  output vmul_pkg::reg_id_t                    out_dst,
  output logic                                 out_dst_we,
  output logic [NUM_LANES-1:0]                 out_mask
);

  localparam int ELEM_W   = 2**LOG2_WIDTH;
  localparam int GRP_W    = NUM_MUL_LANES*ELEM_W;
  localparam int NUM_GRPS = NUM_LANES/NUM_MUL_LANES;
  localparam int CNT_W    = $clog2(NUM_GRPS+1);
  // bit offset of the last group in the full vector
  localparam int TOP_OFS  = (NUM_LANES-NUM_MUL_LANES)*ELEM_W;

  // counts down from G at cycle 1 to 1 at writeback
  logic [CNT_W-1:0]            cyc_cnt;
  // lane registers hold a fresh group this cycle
  logic                        res_vld;
  logic                        we_pend;
  logic                        in_flight;
  logic                        last_cyc;
  logic                        shift_en;
  logic [NUM_LANES*ELEM_W-1:0] res_buf;

  assign in_flight = (cyc_cnt > CNT_W'(1));
  assign last_cyc  = (cyc_cnt == CNT_W'(1));
  // groups 0 to G-2 go into the buffer, the last one is used live
  assign shift_en  = res_vld & in_flight;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cyc_cnt <= '0;
      res_vld <= 1'b0;
      we_pend <= 1'b0;
    end
    else
    begin
      res_vld <= grp.lane_en;
      if (issue)
        cyc_cnt <= CNT_W'(NUM_GRPS);
      else if (cyc_cnt != '0)
        cyc_cnt <= cyc_cnt - 1'b1;
      // squash in the issue cycle or any stall cycle kills the write
      if (issue)
        we_pend <= in_dst_we & ~squash;
      else if (squash && in_flight)
        we_pend <= 1'b0;
    end
  end

  // buffer shifted down one group, newest group on top
  // at writeback this is the whole vector in lane order
  always_comb
  begin
    result = res_buf >> GRP_W;
    result[TOP_OFS +: GRP_W] = grp.res;
  end

  // writeback metadata taken at issue, then the result shift chain
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      out_dst  <= in_dst;
      out_mask <= in_mask;
    end
    if (shift_en)
      res_buf <= result;
  end

  assign out_dst_we = we_pend & last_cyc;

endmodule

// ==== verilog/vmul_unit.sv ====
module vmul_unit #(
  parameter int LOG2_WIDTH    = vmul_pkg::LOG2_WIDTH_DEF,
  parameter int NUM_LANES     = vmul_pkg::NUM_LANES_DEF,
  parameter int NUM_MUL_LANES = vmul_pkg::NUM_MUL_LANES_DEF,
  parameter int REG_ID_WIDTH  = vmul_pkg::REG_ID_WIDTH_DEF
) (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 activate,
  input  vmul_pkg::vmul_op_e                   op,
  input  logic [NUM_LANES*(2**LOG2_WIDTH)-1:0] op_a,
  input  logic [NUM_LANES*(2**LOG2_WIDTH)-1:0] op_b,
  input  logic [NUM_LANES-1:0]                 vmask,
  input  logic [REG_ID_WIDTH-1:0]              in_dst,
  input  logic                                 in_dst_we,
  input  logic                                 squash,
  output logic                                 stall,
  output logic [NUM_LANES*(2**LOG2_WIDTH)-1:0] result,
  output logic [REG_ID_WIDTH-1:0]              out_dst,
  output logic                                 out_dst_we,
  output logic [NUM_LANES-1:0]                 out_mask
);

  // every group must be full, and the id width must match reg_id_t
  if (NUM_LANES % NUM_MUL_LANES != 0)
  begin : g_bad_lanes
    $error("NUM_LANES must be a multiple of NUM_MUL_LANES");
  end
  if (REG_ID_WIDTH != $bits(vmul_pkg::reg_id_t))
  begin : g_bad_reg_id
    $error("REG_ID_WIDTH does not match the package register id type");
  end

  // accepted instruction, from the sequencer
  logic issue;

  vmul_group_if #(
    .ELEM_WIDTH   (2**LOG2_WIDTH),
    .NUM_MUL_LANES(NUM_MUL_LANES)
  ) grp_if ();

  vmul_op_decode i_op_decode (
    .clk     (clk),
    .arst_n  (arst_n),
    .activate(activate),
    .issue   (issue),
    .op      (op),
    .grp     (grp_if.decode)
  );

  vmul_group_sequencer #(
    .LOG2_WIDTH   (LOG2_WIDTH),
    .NUM_LANES    (NUM_LANES),
    .NUM_MUL_LANES(NUM_MUL_LANES)
  ) i_group_sequencer (
    .clk     (clk),
    .arst_n  (arst_n),
    .activate(activate),
    .op_a    (op_a),
    .op_b    (op_b),
    .issue   (issue),
    .stall   (stall),
    .grp     (grp_if.feed)
  );

  // one multiply or shift lane per physical multiplier
  for (genvar i = 0; i < NUM_MUL_LANES; i++)
  begin : g_lane
    vmul_mulshift_lane #(
      .LOG2_WIDTH(LOG2_WIDTH),
      .LANE      (i)
    ) i_mulshift_lane (
      .clk   (clk),
      .arst_n(arst_n),
      .grp   (grp_if.lane)
    );
  end

  vmul_result_collect #(
    .LOG2_WIDTH   (LOG2_WIDTH),
    .NUM_LANES    (NUM_LANES),
    .NUM_MUL_LANES(NUM_MUL_LANES)
  ) i_result_collect (
    .clk       (clk),
    .arst_n    (arst_n),
    .issue     (issue),
    .squash    (squash),
    .in_dst    (in_dst),
    .in_dst_we (in_dst_we),
    .in_mask   (vmask),
    .grp       (grp_if.collect),
    .result    (result),
    .out_dst   (out_dst),
    .out_dst_we(out_dst_we),
    .out_mask  (out_mask)
  );

endmodule

// ==== sim/vmul_unit_sva.sv ====
module vmul_unit_sva #(
  parameter int NUM_GRPS = 4
) (
  input logic clk,
  input logic arst_n,
  input logic issue,
  input logic squash,
  input logic in_dst_we,
  input logic stall,
  input logic out_dst_we
);

  timeunit 1ns;
  timeprecision 100ps;

  // failed assertions so far
  int fail_cnt = 0;

  // stall covers exactly the G-1 cycles after an issue, then drops
  a_stall_len: assert property (@(posedge clk) disable iff (!arst_n)
    issue |=> stall [*(NUM_GRPS-1)] ##1 !stall)
  else
  begin
    $error("stall not high for exactly G-1 cycles after issue");
    fail_cnt++;
  end

  // stall only starts right after an accepted instruction
  a_stall_src: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(stall) |-> $past(issue))
  else
  begin
    $error("stall rose without an issue in the cycle before");
    fail_cnt++;
  end

  // unsquashed write lands exactly G cycles after issue
  a_wb_time: assert property (@(posedge clk) disable iff (!arst_n)
    (issue && in_dst_we && !squash) ##1 (!squash [*(NUM_GRPS-1)]) |=> out_dst_we)
  else
  begin
    $error("out_dst_we missing G cycles after an unsquashed issue");
    fail_cnt++;
  end

  a_wb_src: assert property (@(posedge clk) disable iff (!arst_n)
    out_dst_we |-> $past(issue, NUM_GRPS))
  else
  begin
    $error("out_dst_we without an issue G cycles earlier");
    fail_cnt++;
  end

  // unit comes out of reset idle
  a_reset: assert property (@(posedge clk) $rose(arst_n) |-> (!stall && !out_dst_we))
  else
  begin
    $error("stall or out_dst_we high after reset");
    fail_cnt++;
  end

endmodule

bind vmul_unit vmul_unit_sva #(
  .NUM_GRPS(NUM_LANES / NUM_MUL_LANES)
) i_vmul_unit_sva (
  .clk       (clk),
  .arst_n    (arst_n),
  .issue     (issue),
  .squash    (squash),
  .in_dst_we (in_dst_we),
  .stall     (stall),
  .out_dst_we(out_dst_we)
);

// ==== sim/vmul_unit_tb.sv ====
module vmul_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import vmul_pkg::*;

  localparam int ELEM_W  = 2**LOG2_WIDTH_DEF;
  localparam int LANES   = NUM_LANES_DEF;
  localparam int VEC_W   = LANES*ELEM_W;
  localparam int G       = NUM_LANES_DEF/NUM_MUL_LANES_DEF;
  localparam int CLK_PER = 4;
  localparam int RST_CYC = 4;
  localparam int SEED    = 66518;
  localparam int N_MUL   = 20;
  localparam int N_HI    = 8;
  localparam int N_SH    = 6;
  // instructions over all tests, sizes the watchdog
  localparam int N_INSTR = N_MUL + 1 + 2*(N_HI + 1) + 3*N_SH + 4 + 6 + 3;
  localparam int TIMEOUT = (N_INSTR*(G + 2) + RST_CYC)*CLK_PER;

  typedef logic [VEC_W-1:0] vec_t;
  typedef logic [LANES-1:0] mask_t;

  logic     clk = 1'b0;
  logic     arst_n;
  logic     activate;
  vmul_op_e op;
  vec_t     op_a;
  vec_t     op_b;
  mask_t    vmask;
  reg_id_t  in_dst;
  logic     in_dst_we;
  logic     squash;
  logic     stall;
  vec_t     result;
  reg_id_t  out_dst;
  logic     out_dst_we;
  mask_t    out_mask;

  int cyc = 0;
  int err_cnt = 0;
  int checks = 0;
  int err_mark = 0;
  int tests_run = 0;
  int tests_pass = 0;

  // pending writebacks, one entry per issued instruction
  int      exp_cyc[$];
  logic    exp_we[$];
  reg_id_t exp_dst[$];
  mask_t   exp_mask[$];
  vec_t    exp_res[$];

  vmul_unit i_vmul_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .activate  (activate),
    .op        (op),
    .op_a      (op_a),
    .op_b      (op_b),
    .vmask     (vmask),
    .in_dst    (in_dst),
    .in_dst_we (in_dst_we),
    .squash    (squash),
    .stall     (stall),
    .result    (result),
    .out_dst   (out_dst),
    .out_dst_we(out_dst_we),
    .out_mask  (out_mask)
  );

  always #(CLK_PER/2) clk = ~clk;

  // cycle number, read at the falling edge
  always @(posedge clk)
    cyc <= cyc + 1;

  // one element from the operation rules, products done at full width
  function automatic elem_t ref_elem(vmul_op_e f, elem_t a, elem_t b);
    longint sa;
    longint sb;
    longint ua;
    longint ub;
    int     sh;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = longint'(a);
    ub = longint'(b);
    sh = int'(b[LOG2_WIDTH_DEF-1:0]);
    case (f)
      op_mulh:  return elem_t'((sa * sb) >>> ELEM_W);
      op_mulhu: return elem_t'((ua * ub) >> ELEM_W);
      op_sll:   return elem_t'(ua << sh);
      op_srl:   return elem_t'(ua >> sh);
      op_sra:   return elem_t'(sa >>> sh);
      default:  return elem_t'(sa * sb);
    endcase
  endfunction

  function automatic vec_t ref_vec(vmul_op_e f, vec_t a, vec_t b);
    vec_t r;
    for (int i = 0; i < LANES; i++)
      r[i*ELEM_W +: ELEM_W] = ref_elem(f, a[i*ELEM_W +: ELEM_W], b[i*ELEM_W +: ELEM_W]);
    return r;
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    for (int i = 0; i < LANES; i++)
      v[i*ELEM_W +: ELEM_W] = elem_t'($urandom);
    return v;
  endfunction

  // testbench checks plus the bound assertion failures
  function automatic int total_errs();
    return err_cnt + i_vmul_unit.i_vmul_unit_sva.fail_cnt;
  endfunction

  task automatic check_val(string name, vec_t exp, vec_t got);
    checks++;
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, got);
      err_cnt++;
    end
  endtask

  // compare every due writeback cycle, and no pulse in any other cycle
  always @(negedge clk)
  begin
    if (arst_n)
    begin
      if (exp_cyc.size() > 0 && exp_cyc[0] == cyc)
      begin
        check_val("out_dst_we", vec_t'(exp_we[0]), vec_t'(out_dst_we));
        check_val("out_dst", vec_t'(exp_dst[0]), vec_t'(out_dst));
        check_val("out_mask", vec_t'(exp_mask[0]), vec_t'(out_mask));
        // every lane is checked, masked off or not
        check_val("result", exp_res[0], result);
        void'(exp_cyc.pop_front());
        void'(exp_we.pop_front());
        void'(exp_dst.pop_front());
        void'(exp_mask.pop_front());
        void'(exp_res.pop_front());
      end
      else
      begin
        checks++;
        assert (!out_dst_we)
        else
        begin
          $display("write enable pulse in a cycle with no writeback due");
          err_cnt++;
        end
      end
    end
  end

  // present one instruction, wait for its issue edge, then ride out the stall
  // hold keeps activate up during stall, sq_cyc picks a stall cycle for squash
  task automatic issue_instr(vmul_op_e f, vec_t a, vec_t b, mask_t m, reg_id_t d,
                             logic we, bit hold, int sq_cyc);
    int k;
    activate  = 1'b1;
    op        = f;
    op_a      = a;
    op_b      = b;
    vmask     = m;
    in_dst    = d;
    in_dst_we = we;
    @(negedge clk);
    while (stall)
      @(negedge clk);
    // issue at the next rising edge, writeback G cycles on
    exp_cyc.push_back(cyc + G);
    exp_we.push_back(we && (sq_cyc == 0));
    exp_dst.push_back(d);
    exp_mask.push_back(m);
    exp_res.push_back(ref_vec(f, a, b));
    @(posedge clk);
    #1;
    k = 1;
    // inputs move on, the unit must work from what it captured
    if (!hold)
    begin
      activate  = 1'b0;
      op        = vmul_op_e'($urandom_range(5));
      op_a      = rand_vec();
      op_b      = rand_vec();
      vmask     = mask_t'($urandom);
      in_dst    = reg_id_t'($urandom);
      in_dst_we = 1'b1;
    end
    while (stall)
    begin
      squash = (k == sq_cyc);
      @(posedge clk);
      #1;
      k++;
    end
    squash   = 1'b0;
    activate = 1'b0;
  endtask

  // let the last writeback land, then print the test line
  task automatic end_test(string name);
    int errs;
    while (exp_cyc.size() > 0)
      @(negedge clk);
    @(posedge clk);
    #1;
    errs = total_errs() - err_mark;
    err_mark = total_errs();
    tests_run++;
    if (errs == 0)
      tests_pass++;
    $display("test %-10s %s, %0d errors", name, (errs == 0) ? "ok" : "bad", errs);
  endtask

  initial
  begin
    vec_t a;
    vec_t b;
    void'($urandom(SEED));
    arst_n    = 1'b0;
    activate  = 1'b0;
    op        = op_mull;
    op_a      = '0;
    op_b      = '0;
    vmask     = '0;
    in_dst    = '0;
    in_dst_we = 1'b0;
    squash    = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    #1;
    arst_n = 1'b1;

    for (int i = 0; i < N_MUL; i++)
      issue_instr(op_mull, rand_vec(), rand_vec(), '1, 5'd1, 1'b1, 1'b0, 0);
    // negative extremes against each other and against small values
    a = {16'h8000, 16'h8000, 16'h7fff, 16'hffff, 16'h8000, 16'h0001, 16'hffff, 16'h0000};
    b = {16'h8000, 16'h7fff, 16'h8000, 16'hffff, 16'hffff, 16'h8000, 16'h8000, 16'h1234};
    issue_instr(op_mull, a, b, '1, 5'd2, 1'b1, 1'b0, 0);
    end_test("mull");

    for (int i = 0; i < N_HI; i++)
    begin
      issue_instr(op_mulh, rand_vec(), rand_vec(), '1, 5'd4, 1'b1, 1'b0, 0);
      issue_instr(op_mulhu, rand_vec(), rand_vec(), '1, 5'd5, 1'b1, 1'b0, 0);
    end
    issue_instr(op_mulh, '1, '1, '1, 5'd6, 1'b1, 1'b0, 0);
    issue_instr(op_mulhu, '1, '1, '1, 5'd7, 1'b1, 1'b0, 0);
    end_test("mulh");

    // same operands through all three shifts, lane 0 kept negative
    for (int i = 0; i < N_SH; i++)
    begin
      a = rand_vec();
      a[ELEM_W-1] = 1'b1;
      b = rand_vec();
      issue_instr(op_sll, a, b, '1, 5'd9, 1'b1, 1'b0, 0);
      issue_instr(op_srl, a, b, '1, 5'd10, 1'b1, 1'b0, 0);
      issue_instr(op_sra, a, b, '1, 5'd11, 1'b1, 1'b0, 0);
    end
    end_test("shift");

    issue_instr(op_mull, rand_vec(), rand_vec(), 8'h5a, 5'd17, 1'b1, 1'b0, 0);
    issue_instr(op_mulh, rand_vec(), rand_vec(), 8'h0f, 5'd3, 1'b0, 1'b0, 0);
    issue_instr(op_sra, rand_vec(), rand_vec(), 8'h00, 5'd31, 1'b1, 1'b0, 0);
    issue_instr(op_mulhu, rand_vec(), rand_vec(), 8'hff, 5'd0, 1'b0, 1'b0, 0);
    end_test("metadata");

    // activate held through stall, then issues in the writeback cycle
    issue_instr(op_mull, rand_vec(), rand_vec(), 8'h33, 5'd12, 1'b1, 1'b1, 0);
    issue_instr(op_srl, rand_vec(), rand_vec(), 8'hcc, 5'd13, 1'b1, 1'b1, 0);
    for (int i = 0; i < 4; i++)
      issue_instr(vmul_op_e'(i), rand_vec(), rand_vec(), mask_t'($urandom),
                  reg_id_t'(i + 20), 1'b1, 1'b0, 0);
    end_test("backtoback");

    issue_instr(op_mull, rand_vec(), rand_vec(), 8'h81, 5'd14, 1'b1, 1'b0, 1);
    issue_instr(op_sll, rand_vec(), rand_vec(), 8'h42, 5'd15, 1'b1, 1'b0, 0);
    issue_instr(op_mulh, rand_vec(), rand_vec(), 8'h24, 5'd16, 1'b1, 1'b0, G - 1);
    end_test("squash");

    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_pass, tests_run - tests_pass, checks, total_errs());
    if (total_errs() == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // bound by the instruction count, a stuck stall ends the run here
  initial
  begin
    #(TIMEOUT);
    $display("timeout, the tests did not finish within %0d ns", TIMEOUT);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/vmul_pkg.sv
verilog/vmul_group_if.sv
verilog/vmul_op_decode.sv
verilog/vmul_group_sequencer.sv
verilog/vmul_mulshift_lane.sv
verilog/vmul_result_collect.sv
verilog/vmul_unit.sv
sim/vmul_unit_sva.sv
sim/vmul_unit_tb.sv

// ==== Bender.yml ====
package:
  name: vmul_unit

sources:
  - verilog/vmul_pkg.sv
  - verilog/vmul_group_if.sv
  - verilog/vmul_op_decode.sv
  - verilog/vmul_group_sequencer.sv
  - verilog/vmul_mulshift_lane.sv
  - verilog/vmul_result_collect.sv
  - verilog/vmul_unit.sv
  - target: simulation
    files:
      - sim/vmul_unit_sva.sv
      - sim/vmul_unit_tb.sv
